// File: design/csr_decode.sv
`default_nettype none

module csr_decode (
  input  logic                         instr_valid_i,
  input  logic [mcsr_pkg::XLEN-1:0]    instr_i,
  input  logic [mcsr_pkg::XLEN-1:0]    rs1_data_i,
  input  logic [mcsr_pkg::XLEN-1:0]    pc_i,
  output mcsr_pkg::csr_req_t           req_o
);

  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  localparam logic [31:0] INSN_MRET  = 32'h3020_0073;

  logic                [2:0] funct3;
  logic                [4:0] rs1_idx;  // Also the uimm field
  mcsr_pkg::csr_addr_t       addr;
  logic                      addr_ok;

  assign funct3  = instr_i[14:12];
  assign rs1_idx = instr_i[19:15];
  assign addr    = instr_i[31:20];

  always_comb begin
    case (addr)
      mcsr_pkg::CSR_MSTATUS, mcsr_pkg::CSR_MIE,  mcsr_pkg::CSR_MTVEC,
      mcsr_pkg::CSR_MSCRATCH, mcsr_pkg::CSR_MEPC, mcsr_pkg::CSR_MCAUSE,
      mcsr_pkg::CSR_MTVAL,   mcsr_pkg::CSR_MIP: addr_ok = 1'b1;
      default:                                  addr_ok = 1'b0;
    endcase
  end

  always_comb begin
    req_o         = '0;
    req_o.valid   = instr_valid_i && (instr_i[6:0] == OPC_SYSTEM);
    req_o.addr    = addr;
    req_o.pc      = pc_i;
    req_o.instr   = instr_i;
    req_o.operand = funct3[2] ? {{(mcsr_pkg::XLEN-5){1'b0}}, rs1_idx} : rs1_data_i;
    req_o.op      = mcsr_pkg::CSR_NOP;
    case (funct3)
      3'b000: begin
        if (instr_i[31:7] == '0) req_o.ecall = 1'b1;
        else if (instr_i == INSN_MRET) req_o.mret = 1'b1;
        else req_o.illegal = 1'b1;  // EBREAK, WFI and the rest
      end
      3'b100: req_o.illegal = 1'b1;
      default: begin
        if (!addr_ok) begin
          req_o.illegal = 1'b1;
        end else begin
          req_o.op    = mcsr_pkg::csr_op_e'(funct3[1:0]);
          req_o.wr_en = (funct3[1:0] == 2'b01) || (rs1_idx != 5'd0);
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/csr_file.sv
`default_nettype none

module csr_file #(
  parameter logic [mcsr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100
) (
  input  logic               clk,
  input  logic               rst,
  input  mcsr_pkg::csr_req_t req_i,
  input  logic               meip_i,
  input  logic               mtip_i,
  output mcsr_pkg::csr_res_t res_o
);

  localparam int XLEN = mcsr_pkg::XLEN;

  mcsr_pkg::mstatus_u mstatus_q, mstatus_d;
  mcsr_pkg::mstatus_u new_view;  // Write data seen as mstatus fields
  logic [XLEN-1:0]    mie_q, mip_q, mtvec_q, mcause_q;
  logic [XLEN-1:0]    mscratch_q, mepc_q, mtval_q;
  logic [XLEN-1:0]    mip_rd, old_val, new_val, trap_cause;
  logic               is_illegal, is_ecall, irq_mei, irq_mti;
  logic               take_trap, do_mret, do_write;

  always_comb begin
    mip_rd = mip_q;
    mip_rd[mcsr_pkg::IRQ_MEI] = mip_q[mcsr_pkg::IRQ_MEI] | meip_i;
    mip_rd[mcsr_pkg::IRQ_MTI] = mip_q[mcsr_pkg::IRQ_MTI] | mtip_i;
  end

  //////////////////////////////////////////////////
  // Trap selection
  //////////////////////////////////////////////////
  assign is_illegal = req_i.valid && req_i.illegal;
  assign is_ecall   = req_i.valid && req_i.ecall;
  assign irq_mei    = mstatus_q.f.mie && mie_q[mcsr_pkg::IRQ_MEI] && mip_rd[mcsr_pkg::IRQ_MEI];
  assign irq_mti    = mstatus_q.f.mie && mie_q[mcsr_pkg::IRQ_MTI] && mip_rd[mcsr_pkg::IRQ_MTI];
  assign take_trap  = is_illegal || is_ecall || irq_mei || irq_mti;
  assign do_mret    = req_i.valid && req_i.mret && !take_trap;
  assign do_write   = req_i.valid && req_i.wr_en && !take_trap;

  always_comb begin
    if (is_illegal)    trap_cause = mcsr_pkg::CAUSE_ILLEGAL;
    else if (is_ecall) trap_cause = mcsr_pkg::CAUSE_ECALL;
    else if (irq_mei)  trap_cause = mcsr_pkg::CAUSE_MEI;
    else               trap_cause = mcsr_pkg::CAUSE_MTI;
  end

  // Old value, also the rd data
  always_comb begin
    case (req_i.addr)
      mcsr_pkg::CSR_MSTATUS:  old_val = mstatus_q.raw;
      mcsr_pkg::CSR_MIE:      old_val = mie_q;
      mcsr_pkg::CSR_MTVEC:    old_val = mtvec_q;
      mcsr_pkg::CSR_MSCRATCH: old_val = mscratch_q;
      mcsr_pkg::CSR_MEPC:     old_val = mepc_q;
      mcsr_pkg::CSR_MCAUSE:   old_val = mcause_q;
      mcsr_pkg::CSR_MTVAL:    old_val = mtval_q;
      mcsr_pkg::CSR_MIP:      old_val = mip_rd;
      default:                old_val = '0;  // ECALL and MRET land here
    endcase
  end

  always_comb begin
    case (req_i.op)
      mcsr_pkg::CSR_RW: new_val = req_i.operand;
      mcsr_pkg::CSR_RS: new_val = old_val | req_i.operand;
      mcsr_pkg::CSR_RC: new_val = old_val & ~req_i.operand;
      default:          new_val = old_val;
    endcase
  end

  always_comb begin
    new_view.raw = new_val;
    mstatus_d    = mstatus_q;
    if (take_trap) begin
      mstatus_d.f.mpie = mstatus_q.f.mie;
      mstatus_d.f.mie  = 1'b0;
    end else if (do_mret) begin
      mstatus_d.f.mie  = mstatus_q.f.mpie;
      mstatus_d.f.mpie = 1'b1;
    end else if (do_write && req_i.addr == mcsr_pkg::CSR_MSTATUS) begin
      mstatus_d.raw    = '0;  // Everything else hardwired
      mstatus_d.f.mie  = new_view.f.mie;
      mstatus_d.f.mpie = new_view.f.mpie;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= '0;
      mie_q         <= '0;
      mip_q         <= '0;
      mtvec_q       <= MTVEC_RESET;
      mcause_q      <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      if (take_trap) begin
        mcause_q <= trap_cause;
      end else if (do_write) begin
        case (req_i.addr)
          mcsr_pkg::CSR_MIE:    mie_q    <= new_val & mcsr_pkg::MIE_MASK;
          mcsr_pkg::CSR_MIP:    mip_q    <= new_val & mcsr_pkg::MIE_MASK;
          mcsr_pkg::CSR_MTVEC:  mtvec_q  <= {new_val[XLEN-1:2], 2'b00};  // Direct mode only
          mcsr_pkg::CSR_MCAUSE: mcause_q <= new_val;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_trap) begin
      mepc_q  <= {req_i.pc[XLEN-1:2], 2'b00};
      mtval_q <= is_illegal ? req_i.instr : '0;
    end else if (do_write) begin
      case (req_i.addr)
        mcsr_pkg::CSR_MSCRATCH: mscratch_q <= new_val;
        mcsr_pkg::CSR_MEPC:     mepc_q     <= {new_val[XLEN-1:2], 2'b00};
        mcsr_pkg::CSR_MTVAL:    mtval_q    <= new_val;
        default: ;
      endcase
    end
  end

  // MRET retires with a writeback to x0 and carries mepc as target
  assign res_o.rd_valid    = req_i.valid && !take_trap;
  assign res_o.rd_data     = old_val;
  assign res_o.trap        = take_trap;
  assign res_o.redirect_pc = take_trap ? mtvec_q : mepc_q;

endmodule

`default_nettype wire

// File: design/csr_result.sv
`default_nettype none

module csr_result (
  input  logic                        clk,
  input  logic                        rst,
  input  mcsr_pkg::csr_res_t          res_i,
  output logic                        rd_valid_o,
  output logic [mcsr_pkg::XLEN-1:0]   rd_data_o,
  output logic                        trap_o,
  output logic [mcsr_pkg::XLEN-1:0]   redirect_pc_o
);

  // Pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_o <= 1'b0;
      trap_o     <= 1'b0;
    end else begin
      rd_valid_o <= res_i.rd_valid;
      trap_o     <= res_i.trap;
    end
  end

  //////////////////////////////////////////////////
  // Payload, held between pulses
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (res_i.rd_valid) begin
      rd_data_o <= res_i.rd_data;
    end
    if (res_i.rd_valid || res_i.trap) begin
      redirect_pc_o <= res_i.redirect_pc;  // mtvec on trap, mepc otherwise
    end
  end

endmodule

`default_nettype wire

// File: design/csr_timer.sv
`default_nettype none

module csr_timer #(
  parameter int unsigned TIMER_STEP = 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        tmr_we_i,
  input  mcsr_pkg::mtime_sel_e        tmr_sel_i,
  input  logic [mcsr_pkg::XLEN-1:0]   tmr_wdata_i,
  output logic [mcsr_pkg::XLEN-1:0]   tmr_rdata_o,
  output logic                        mtip_o
);

  logic [63:0] mtime_q, mtimecmp_q;
  logic [63:0] mtime_d, mtimecmp_d;

  // Word reads, no latency
  always_comb begin
    case (tmr_sel_i)
      mcsr_pkg::MTIME_LO:    tmr_rdata_o = mtime_q[31:0];
      mcsr_pkg::MTIME_HI:    tmr_rdata_o = mtime_q[63:32];
      mcsr_pkg::MTIMECMP_LO: tmr_rdata_o = mtimecmp_q[31:0];
      default:               tmr_rdata_o = mtimecmp_q[63:32];
    endcase
  end

  always_comb begin
    mtime_d    = mtime_q + 64'(TIMER_STEP);
    mtimecmp_d = mtimecmp_q;
    if (tmr_we_i) begin
      case (tmr_sel_i)
        mcsr_pkg::MTIME_LO:    mtime_d    = {mtime_q[63:32], tmr_wdata_i};  // No tick
        mcsr_pkg::MTIME_HI:    mtime_d    = {tmr_wdata_i, mtime_q[31:0]};
        mcsr_pkg::MTIMECMP_LO: mtimecmp_d = {mtimecmp_q[63:32], tmr_wdata_i};
        default:               mtimecmp_d = {tmr_wdata_i, mtimecmp_q[31:0]};
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // Far future, no interrupt out of reset
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
    end
  end

  assign mtip_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// File: design/mcsr_pkg.sv
`default_nettype none

package mcsr_pkg;

  localparam int XLEN = 32;

  typedef logic [11:0] csr_addr_t;

  //////////////////////////////////////////////////
  // Machine CSR numbers
  //////////////////////////////////////////////////
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  // Matches funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    CSR_NOP = 2'b00,
    CSR_RW  = 2'b01,
    CSR_RS  = 2'b10,
    CSR_RC  = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic            valid;
    csr_op_e         op;
    csr_addr_t       addr;
    logic [XLEN-1:0] operand;
    logic            wr_en;    // Low for RS/RC with zero source
    logic            illegal;
    logic            ecall;
    logic            mret;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;    // Goes to mtval
  } csr_req_t;

  typedef struct packed {
    logic [31:8] wpri_hi;
    logic        mpie;
    logic [6:4]  wpri_mid;
    logic        mie;
    logic [2:0]  wpri_lo;
  } mstatus_fields_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    mstatus_fields_t f;
  } mstatus_u;

  typedef struct packed {
    logic            rd_valid;
    logic [XLEN-1:0] rd_data;
    logic            trap;
    logic [XLEN-1:0] redirect_pc;
  } csr_res_t;

  //////////////////////////////////////////////////
  // Trap causes and interrupt bits
  //////////////////////////////////////////////////
  localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;
  localparam logic [XLEN-1:0] CAUSE_ECALL   = 32'd11;
  localparam logic [XLEN-1:0] CAUSE_MTI     = 32'h8000_0007;
  localparam logic [XLEN-1:0] CAUSE_MEI     = 32'h8000_000B;

  localparam int IRQ_MTI = 7;
  localparam int IRQ_MEI = 11;
  localparam logic [XLEN-1:0] MIE_MASK = 32'h0000_0880;  // MEIE and MTIE

  typedef enum logic [1:0] {
    MTIME_LO    = 2'b00,
    MTIME_HI    = 2'b01,
    MTIMECMP_LO = 2'b10,
    MTIMECMP_HI = 2'b11
  } mtime_sel_e;

endpackage

`default_nettype wire

// File: design/mcsr_top.sv
`default_nettype none

module mcsr_top #(
  parameter logic [mcsr_pkg::XLEN-1:0] MTVEC_RESET = 32'h0000_0100,
  parameter int unsigned               TIMER_STEP  = 1
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        instr_valid_i,
  input  logic [mcsr_pkg::XLEN-1:0]   instr_i,
  input  logic [mcsr_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [mcsr_pkg::XLEN-1:0]   pc_i,
  input  logic                        meip_i,     // Level
  input  logic                        tmr_we_i,
  input  mcsr_pkg::mtime_sel_e        tmr_sel_i,
  input  logic [mcsr_pkg::XLEN-1:0]   tmr_wdata_i,
  output logic [mcsr_pkg::XLEN-1:0]   tmr_rdata_o,
  output logic                        rd_valid_o,
  output logic [mcsr_pkg::XLEN-1:0]   rd_data_o,
  output logic                        trap_o,
  output logic [mcsr_pkg::XLEN-1:0]   redirect_pc_o
);

  mcsr_pkg::csr_req_t req;
  mcsr_pkg::csr_res_t res;
  logic               mtip;

  csr_decode u_decode (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs1_data_i    (rs1_data_i),
    .pc_i          (pc_i),
    .req_o         (req)
  );

  csr_file #(.MTVEC_RESET(MTVEC_RESET)) u_file (
    .clk    (clk),
    .rst    (rst),
    .req_i  (req),
    .meip_i (meip_i),
    .mtip_i (mtip),
    .res_o  (res)
  );

  csr_timer #(.TIMER_STEP(TIMER_STEP)) u_timer (
    .clk         (clk),
    .rst         (rst),
    .tmr_we_i    (tmr_we_i),
    .tmr_sel_i   (tmr_sel_i),
    .tmr_wdata_i (tmr_wdata_i),
    .tmr_rdata_o (tmr_rdata_o),
    .mtip_o      (mtip)
  );

  csr_result u_result (
    .clk           (clk),
    .rst           (rst),
    .res_i         (res),
    .rd_valid_o    (rd_valid_o),
    .rd_data_o     (rd_data_o),
    .trap_o        (trap_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

`default_nettype wire

// File: mcsr_sub.f
design/mcsr_pkg.sv
design/csr_decode.sv
design/csr_file.sv
design/csr_timer.sv
design/csr_result.sv
design/mcsr_top.sv
verif/mcsr_properties.sv
verif/mcsr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mcsr_sub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module mcsr_tb \
  -f mcsr_sub.f -o mcsr_sim

# Exit status is nonzero on any $fatal
./obj_dir/mcsr_sim

// File: verif/mcsr_properties.sv
`default_nettype none

module mcsr_properties (
  input logic                      clk,
  input logic                      rst,
  input logic                      instr_valid_i,
  input logic [31:0]               instr_i,
  input logic [31:0]               rs1_data_i,
  input logic [31:0]               pc_i,
  input logic                      meip_i,
  input logic                      tmr_we_i,
  input mcsr_pkg::mtime_sel_e      tmr_sel_i,
  input logic [31:0]               tmr_rdata_o,
  input logic                      rd_valid_o,
  input logic [31:0]               rd_data_o,
  input logic                      trap_o,
  input logic [31:0]               redirect_pc_o,
  input logic [31:0]               mstatus_i,
  input logic [31:0]               mie_i,
  input logic [31:0]               mtvec_i,
  input logic [31:0]               mscratch_i,
  input logic [31:0]               mepc_i,
  input logic [31:0]               mcause_i,
  input logic [31:0]               mtval_i,
  input logic [63:0]               mtime_i,
  input logic [63:0]               mtimecmp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Polled by the testbench

  logic [2:0]  funct3;
  logic [11:0] addr;
  logic [31:0] opnd, exp_val;
  logic        is_sys, known_addr, rmw_hit, illegal_hit, ecall_hit;

  assign funct3 = instr_i[14:12];
  assign addr   = instr_i[31:20];
  assign opnd   = funct3[2] ? {27'd0, instr_i[19:15]} : rs1_data_i;
  assign is_sys = instr_valid_i && (instr_i[6:0] == 7'h73);
  assign known_addr = addr inside {12'h300, 12'h304, 12'h305, 12'h340,
                                   12'h341, 12'h342, 12'h343, 12'h344};

  always_comb begin
    case (funct3[1:0])
      2'b01:   exp_val = opnd;
      2'b10:   exp_val = mscratch_i | opnd;
      default: exp_val = mscratch_i & ~opnd;
    endcase
  end

  // Only with interrupts globally off, so nothing preempts the access
  assign rmw_hit = is_sys && addr == 12'h340 && funct3[1:0] != 2'b00 && !mstatus_i[3]
                   && !$isunknown(mscratch_i);
  assign illegal_hit = is_sys && funct3 != 3'b000 && funct3 != 3'b100 && !known_addr;
  assign ecall_hit   = instr_valid_i && instr_i == 32'h0000_0073;

  //////////////////////////////////////////////////
  // CSR access
  //////////////////////////////////////////////////
  a_rmw_rd: assert property (@(posedge clk) disable iff (rst)
    rmw_hit |=> rd_valid_o && rd_data_o == $past(mscratch_i))
    else begin
      fail_cnt++;
      $error("Mismatch rd_data_o: got %h expected %h", rd_data_o, $past(mscratch_i));
    end

  a_rmw_val: assert property (@(posedge clk) disable iff (rst)
    rmw_hit |=> mscratch_i == $past(exp_val))
    else begin
      fail_cnt++;
      $error("Mismatch mscratch: got %h expected %h", mscratch_i, $past(exp_val));
    end

  a_masks: assert property (@(posedge clk) disable iff (rst)
    mtvec_i[1:0] == 2'b00 && (mepc_i[1:0] == 2'b00 || $isunknown(mepc_i))
    && (mie_i & ~32'h0000_0880) == 32'd0)
    else begin
      fail_cnt++;
      $error("Mismatch masks: mtvec %h mepc %h mie %h", mtvec_i, mepc_i, mie_i);
    end

  a_redirect: assert property (@(posedge clk) disable iff (rst)
    trap_o |-> redirect_pc_o == $past(mtvec_i))
    else begin
      fail_cnt++;
      $error("Mismatch redirect_pc_o: got %h expected %h", redirect_pc_o, $past(mtvec_i));
    end

  //////////////////////////////////////////////////
  // Exceptions
  //////////////////////////////////////////////////
  a_illegal: assert property (@(posedge clk) disable iff (rst)
    illegal_hit |=> trap_o && mcause_i == 32'd2 && mtval_i == $past(instr_i)
    && mepc_i == {$past(pc_i[31:2]), 2'b00})
    else begin
      fail_cnt++;
      $error("Mismatch illegal trap: trap %h mcause %h mtval %h", trap_o, mcause_i, mtval_i);
    end

  a_ecall: assert property (@(posedge clk) disable iff (rst)
    ecall_hit |=> trap_o && mcause_i == 32'd11 && mepc_i == {$past(pc_i[31:2]), 2'b00})
    else begin
      fail_cnt++;
      $error("Mismatch ecall trap: trap %h mcause %h mepc %h", trap_o, mcause_i, mepc_i);
    end

  //////////////////////////////////////////////////
  // Timer and interrupts
  //////////////////////////////////////////////////
  a_tick: assert property (@(posedge clk) disable iff (rst)
    tmr_sel_i == mcsr_pkg::MTIME_LO && $past(tmr_sel_i) == mcsr_pkg::MTIME_LO
    && !$past(tmr_we_i) && !$past(rst) |-> tmr_rdata_o == $past(tmr_rdata_o) + 32'd1)
    else begin
      fail_cnt++;
      $error("Mismatch tmr_rdata_o: got %h expected %h", tmr_rdata_o,
             $past(tmr_rdata_o) + 32'd1);
    end

  a_mti: assert property (@(posedge clk) disable iff (rst)
    mtime_i >= mtimecmp_i && mie_i == 32'h80 && mstatus_i[3] && !instr_valid_i
    |=> trap_o && mcause_i == 32'h8000_0007)
    else begin
      fail_cnt++;
      $error("Mismatch timer trap: trap %h mcause %h", trap_o, mcause_i);
    end

  a_mei_off: assert property (@(posedge clk) disable iff (rst)
    meip_i && !mstatus_i[3] && !instr_valid_i |=> !trap_o)
    else begin
      fail_cnt++;
      $error("Mismatch trap_o: got %h expected %h", trap_o, 1'b0);
    end

  a_mei_take: assert property (@(posedge clk) disable iff (rst)
    meip_i && mstatus_i[3] && mie_i[11] && !instr_valid_i
    |=> trap_o && mcause_i == 32'h8000_000B && !mstatus_i[3] && mstatus_i[7]
    && mepc_i == {$past(pc_i[31:2]), 2'b00})
    else begin
      fail_cnt++;
      $error("Mismatch external trap: mcause %h mstatus %h mepc %h", mcause_i, mstatus_i,
             mepc_i);
    end

  a_mret: assert property (@(posedge clk) disable iff (rst)
    instr_valid_i && instr_i == 32'h3020_0073 && !mstatus_i[3]
    |=> redirect_pc_o == $past(mepc_i) && mstatus_i[3] == $past(mstatus_i[7]) && mstatus_i[7])
    else begin
      fail_cnt++;
      $error("Mismatch mret: redirect_pc_o %h mstatus %h", redirect_pc_o, mstatus_i);
    end

endmodule

bind mcsr_top mcsr_properties u_props (
  .clk (clk), .rst (rst), .instr_valid_i (instr_valid_i), .instr_i (instr_i),
  .rs1_data_i (rs1_data_i), .pc_i (pc_i), .meip_i (meip_i), .tmr_we_i (tmr_we_i),
  .tmr_sel_i (tmr_sel_i), .tmr_rdata_o (tmr_rdata_o), .rd_valid_o (rd_valid_o),
  .rd_data_o (rd_data_o), .trap_o (trap_o), .redirect_pc_o (redirect_pc_o),
  .mstatus_i (u_file.mstatus_q.raw), .mie_i (u_file.mie_q), .mtvec_i (u_file.mtvec_q),
  .mscratch_i (u_file.mscratch_q), .mepc_i (u_file.mepc_q), .mcause_i (u_file.mcause_q),
  .mtval_i (u_file.mtval_q), .mtime_i (u_timer.mtime_q), .mtimecmp_i (u_timer.mtimecmp_q)
);

`default_nettype wire

// File: verif/mcsr_tb.sv
`default_nettype none

module mcsr_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 instr_valid_i = 1'b0;
  logic [31:0]          instr_i = '0, rs1_data_i = '0, pc_i = '0, tmr_wdata_i = '0;
  logic                 meip_i = 1'b0, tmr_we_i = 1'b0;
  mcsr_pkg::mtime_sel_e tmr_sel_i = mcsr_pkg::MTIME_LO;
  logic [31:0]          tmr_rdata_o, rd_data_o, redirect_pc_o;
  logic                 rd_valid_o, trap_o;
  integer               seed = 32'h6e2ed367;

  always #20 clk = ~clk;

  mcsr_top #(.MTVEC_RESET(32'h0000_0100), .TIMER_STEP(1)) u_dut (.*);

  function automatic logic [31:0] csr_insn(input logic [11:0] addr, input logic [2:0] f3,
                                           input logic [4:0] src);
    return {addr, src, f3, 5'd1, 7'h73};
  endfunction

  task automatic fail_stop(input string why);
    $display("TB FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] pc);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= insn;
    rs1_data_i    <= rs1;
    pc_i          <= pc;
    @(posedge clk);
    instr_valid_i <= 1'b0;
  endtask

  task automatic timer_write(input mcsr_pkg::mtime_sel_e sel, input logic [31:0] data);
    @(posedge clk);
    tmr_we_i    <= 1'b1;
    tmr_sel_i   <= sel;
    tmr_wdata_i <= data;
    @(posedge clk);
    tmr_we_i  <= 1'b0;
    tmr_sel_i <= mcsr_pkg::MTIME_LO;
  endtask

  task automatic await_trap(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (trap_o !== 1'b1) begin
      cycles++;
      if (cycles > 20) fail_stop({"No trap seen for ", what});
      @(negedge clk);
    end
  endtask

  // Catch assertion failures as they happen
  always @(negedge clk) begin
    if (u_dut.u_props.fail_cnt != 0) fail_stop("An assertion failed");
  end

  initial begin
    logic [2:0] f3;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    issue(csr_insn(12'h340, 3'b001, 5'd3), $random(seed), 32'h200);  // Known mscratch first
    for (int i = 0; i < 24; i++) begin
      f3 = {($random(seed) & 1) != 0, 2'b00};
      f3[1:0] = 2'($unsigned($random(seed)) % 3 + 1);
      issue(csr_insn(12'h340, f3, 5'($random(seed))), $random(seed), 32'h204 + 4 * i);
    end

    ////////////////////////////////////////////////// Masks and exceptions
    issue(csr_insn(12'h305, 3'b001, 5'd2), 32'h0000_1003, 32'h300);
    issue(csr_insn(12'h341, 3'b001, 5'd2), 32'h0000_0a57, 32'h304);
    issue(csr_insn(12'h304, 3'b001, 5'd2), 32'hffff_ffff, 32'h308);
    issue(csr_insn(12'h304, 3'b001, 5'd2), 32'h0, 32'h30c);
    issue(csr_insn(12'h7c0, 3'b001, 5'd2), 32'h1234, 32'h310);  // Unimplemented
    await_trap("illegal CSR");
    issue(32'h0000_0073, 32'h0, 32'h314);
    await_trap("ECALL");

    ////////////////////////////////////////////////// Timer
    repeat (6) @(posedge clk);
    issue(csr_insn(12'h304, 3'b001, 5'd2), 32'h0000_0080, 32'h400);
    issue(csr_insn(12'h300, 3'b001, 5'd2), 32'h0000_0008, 32'h404);
    timer_write(mcsr_pkg::MTIMECMP_HI, 32'h0);
    timer_write(mcsr_pkg::MTIMECMP_LO, 32'h0);
    await_trap("timer interrupt");
    timer_write(mcsr_pkg::MTIMECMP_LO, 32'hffff_ffff);
    timer_write(mcsr_pkg::MTIMECMP_HI, 32'hffff_ffff);

    ////////////////////////////////////////////////// External interrupt and MRET
    issue(csr_insn(12'h304, 3'b001, 5'd2), 32'h0000_0800, 32'h500);
    @(posedge clk);
    meip_i <= 1'b1;
    repeat (4) @(posedge clk);
    issue(csr_insn(12'h300, 3'b110, 5'd8), 32'h0, 32'h504);  // csrrsi sets MIE
    pc_i <= 32'h0000_0540;  // pc of the interrupted instruction
    await_trap("external interrupt");
    @(posedge clk);
    meip_i <= 1'b0;
    issue(32'h3020_0073, 32'h0, 32'h600);
    repeat (4) @(posedge clk);

    if (u_dut.u_props.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_stop("Assertion failures at end of run");
    end
  end

endmodule

`default_nettype wire
